//--- design/inst_class_decode.sv
/*
  first decode stage: splits the instruction word into class, width, operand
  register and per-class flags; purely combinational
*/
`timescale 1ns/10ps
`include "inst_decoder_params.svh"

module inst_class_decode (
	input logic [`INST_BITS-1:0] inst,
	input logic pre_stage,
	inst_fields_if.producer fields
);
	logic b8;
	logic e;
	logic m;
	logic d;
	logic z;
	logic [2:0] aaa;
	logic [1:0] rr;
	logic [5:0] imm6;
	logic [2:0] mdz;
	logic [3:0] cccc;

	// two top bits pick the kind, low bit splits ror/rol
	function automatic inst_decoder_pkg::shift_e shift_kind(input logic [2:0] s);
		case (s[2:1])
			2'b10: return inst_decoder_pkg::sh_shr;
			2'b01: return inst_decoder_pkg::sh_sar;
			2'b11: return inst_decoder_pkg::sh_shl;
			default: return s[0] ? inst_decoder_pkg::sh_rol : inst_decoder_pkg::sh_ror;
		endcase
	endfunction

	// b8 e aaa m rr d z iiiiii from the top bit down
	assign {b8, e, aaa, m, rr, d, z, imm6} = inst;
	assign mdz = {m, d, z};
	// branch form reuses aaa[0], m and rr as the condition
	assign cccc = inst[11:8];

	assign fields.mdz = mdz;
	assign fields.imm6 = imm6;
	assign fields.cc = cccc;
	assign fields.binop = inst_decoder_pkg::op_e'(aaa);

	always_comb begin
		fields.cls = inst_decoder_pkg::cls_mov;
		fields.wide = 1'b0;
		fields.r = 3'd0;
		fields.shift = shift_kind(aaa);
		fields.use_zp = !m;
		fields.use_imm8 = 1'b0;
		fields.branch = 1'b0;
		fields.jump = 1'b0;
		fields.cmptest = 1'b0;
		fields.effective_d = d;
		fields.need_pre_stage = 1'b0;

		if (b8 || e) begin
			// alu binop or shift, r8 when b8 set
			fields.wide = !b8;
			fields.r = {rr, e & b8};
			fields.cmptest = (aaa == 3'b111);
			if (mdz == 3'b111) begin
				fields.cls = inst_decoder_pkg::cls_shift;
				fields.effective_d = 1'b0;
			end else begin
				fields.cls = inst_decoder_pkg::cls_alu;
			end
			// cmp and test never write through d
			if (aaa == 3'b111)
				fields.effective_d = 1'b0;
		end else if (aaa[2] || aaa[1]) begin
			// move group, r16 when aaa[2] clear
			fields.wide = !aaa[2];
			fields.r = {rr, aaa[1] & aaa[2]};
			// low imm6 bits are the count here
			fields.shift = shift_kind({imm6[5:4], 1'b0});
			if (!aaa[0]) begin
				if (m) begin
					// mov r, imm8
					fields.use_imm8 = 1'b1;
					fields.effective_d = 1'b0;
				end
				if ({m, d} == 2'b00 && rr == 2'b00) begin
					// jump, emitted once the push is out
					fields.jump = !pre_stage;
					if (!fields.wide) begin
						// jump src, z turns it into call src
						fields.wide = 1'b1;
						fields.use_zp = 1'b0;
						fields.need_pre_stage = z;
					end
				end
				if ({m, d} == 2'b01)
					fields.cls = inst_decoder_pkg::cls_swap;
			end else begin
				if (mdz == 3'b101)
					fields.cls = inst_decoder_pkg::cls_shift;
				else if (mdz == 3'b111)
					fields.cls = inst_decoder_pkg::cls_swap;
			end
		end else begin
			// conditional branch, pc plus imm8
			fields.wide = 1'b1;
			fields.branch = 1'b1;
			fields.use_imm8 = 1'b1;
			fields.effective_d = 1'b0;
			fields.need_pre_stage = (cccc == `CC_CALL);
		end
	end
endmodule

//--- design/inst_decoder.sv
/*
  instruction decoder top level: class decode, operand decode, sequencer
  the registered micro-op leaves on one plain port per field
*/
`timescale 1ns/10ps
`include "inst_decoder_params.svh"

module inst_decoder (
	input logic clk,
	input logic rst,
	input logic inst_valid,
	input logic [`INST_BITS-1:0] inst,
	output logic inst_done,
	output logic uop_valid,
	input logic uop_ready,
	output inst_decoder_pkg::op_e uop_op,
	output inst_decoder_pkg::dest_e uop_dest,
	output inst_decoder_pkg::src_e uop_src,
	output logic [`REG_IDX_BITS-1:0] uop_reg_dest,
	output logic [`REG_IDX_BITS-1:0] uop_reg_src,
	output logic uop_wide,
	output logic uop_wide2,
	output logic uop_src_sext,
	output inst_decoder_pkg::addr_src_e uop_addr_src,
	output logic [`REG_IDX_BITS-1:0] uop_addr_reg,
	output logic uop_autoinc,
	output logic uop_autoinc_neg,
	output logic uop_src1_pc,
	output logic uop_update_dest,
	output logic uop_upd_carry,
	output logic uop_upd_flags,
	output logic uop_use_cc,
	output logic [3:0] uop_cc,
	output inst_decoder_pkg::shift_e uop_shift,
	output logic [1:0] uop_imm_words
);
	inst_decoder_pkg::uop_t uop_next;
	inst_decoder_pkg::uop_t uop_q;
	logic pre_stage;

	inst_fields_if fields ();

	inst_class_decode u_class (
		.inst(inst),
		.pre_stage(pre_stage),
		.fields(fields.producer)
	);

	operand_decode u_operand (
		.fields(fields.consumer),
		.pre_stage(pre_stage),
		.uop(uop_next)
	);

	uop_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.inst_valid(inst_valid),
		.need_pre_stage(fields.need_pre_stage),
		.uop_next(uop_next),
		.pre_stage(pre_stage),
		.inst_done(inst_done),
		.uop_valid(uop_valid),
		.uop_ready(uop_ready),
		.uop(uop_q)
	);

	// flatten the registered micro-op
	assign uop_op = uop_q.op;
	assign uop_dest = uop_q.dest;
	assign uop_src = uop_q.src;
	assign uop_reg_dest = uop_q.reg_dest;
	assign uop_reg_src = uop_q.reg_src;
	assign uop_wide = uop_q.wide;
	assign uop_wide2 = uop_q.wide2;
	assign uop_src_sext = uop_q.src_sext;
	assign uop_addr_src = uop_q.addr_src;
	assign uop_addr_reg = uop_q.addr_reg;
	assign uop_autoinc = uop_q.autoinc;
	assign uop_autoinc_neg = uop_q.autoinc_neg;
	assign uop_src1_pc = uop_q.src1_pc;
	assign uop_update_dest = uop_q.update_dest;
	assign uop_upd_carry = uop_q.upd_carry;
	assign uop_upd_flags = uop_q.upd_flags;
	assign uop_use_cc = uop_q.use_cc;
	assign uop_cc = uop_q.cc;
	assign uop_shift = uop_q.shift;
	assign uop_imm_words = uop_q.imm_words;
endmodule

//--- design/inst_decoder_params.svh
/*
  widths and fixed indices for the instruction decoder
  include wherever an instruction or register index width is needed
*/
`ifndef INST_DECODER_PARAMS_SVH
`define INST_DECODER_PARAMS_SVH

// instruction word width
`define INST_BITS 16

// register index width
// upper half of the index space is special registers
`define REG_IDX_BITS 4

// stack pointer index, sized to REG_IDX_BITS
`define REG_INDEX_SP 4'd7

// branch condition code that turns a branch into a call
`define CC_CALL 4'd15

`endif

//--- design/inst_decoder_pkg.sv
/*
  types shared by the decode stages: enums and the packed micro-op
*/
`include "inst_decoder_params.svh"

package inst_decoder_pkg;

	// instruction class
	typedef enum logic [1:0] {cls_alu, cls_mov, cls_swap, cls_shift} cls_e;

	// alu op, numbered to match the aaa field
	typedef enum logic [2:0] {
		op_add, op_sub, op_adc, op_sbc, op_and, op_or, op_xor, op_mov
	} op_e;

	// operand-2 source
	typedef enum logic [2:0] {
		src_reg, src_imm2, src_imm6, src_imm8, src_imm16, src_mem
	} src_e;

	typedef enum logic [1:0] {dest_reg, dest_mem, dest_pc, dest_imm8} dest_e;

	// offset added to the address base register
	typedef enum logic [2:0] {
		asrc_none, asrc_reg, asrc_imm2, asrc_imm7, asrc_imm16
	} addr_src_e;

	typedef enum logic [2:0] {sh_ror, sh_rol, sh_shl, sh_shr, sh_sar} shift_e;

	// one execution step
	typedef struct packed {
		op_e op;
		dest_e dest;
		src_e src;
		logic [`REG_IDX_BITS-1:0] reg_dest;
		logic [`REG_IDX_BITS-1:0] reg_src;
		logic wide;
		logic wide2;
		logic src_sext;
		addr_src_e addr_src;
		logic [`REG_IDX_BITS-1:0] addr_reg;
		logic autoinc;
		// 1 = decrement
		logic autoinc_neg;
		logic src1_pc;
		logic update_dest;
		logic upd_carry;
		logic upd_flags;
		logic use_cc;
		logic [3:0] cc;
		shift_e shift;
		// pc offset in words for a pushed return address
		logic [1:0] imm_words;
	} uop_t;

endpackage

//--- design/inst_fields_if.sv
/*
  class-decode results passed to the operand decoder
  class decode drives the producer side, operand decode reads the consumer side
*/
`timescale 1ns/10ps

interface inst_fields_if;
	inst_decoder_pkg::cls_e cls;
	logic wide;
	// first operand register, r8 or r16 index
	logic [2:0] r;
	inst_decoder_pkg::op_e binop;
	inst_decoder_pkg::shift_e shift;
	logic use_zp;
	logic use_imm8;
	logic branch;
	logic jump;
	logic cmptest;
	logic effective_d;
	logic need_pre_stage;
	logic [2:0] mdz;
	logic [5:0] imm6;
	// branch condition
	logic [3:0] cc;

	modport producer (
		output cls, wide, r, binop, shift, use_zp, use_imm8, branch, jump,
		output cmptest, effective_d, need_pre_stage, mdz, imm6, cc
	);

	modport consumer (
		input cls, wide, r, binop, shift, use_zp, use_imm8, branch, jump,
		input cmptest, effective_d, need_pre_stage, mdz, imm6, cc
	);
endinterface

//--- design/operand_decode.sv
/*
  second decode stage for the operand-2 addressing mode and derived control,
  assembled into one combinational micro-op for the current stage
*/
`timescale 1ns/10ps
`include "inst_decoder_params.svh"

module operand_decode (
	inst_fields_if.consumer fields,
	input logic pre_stage,
	output inst_decoder_pkg::uop_t uop
);
	logic [5:0] imm6;
	logic d;
	logic [`REG_IDX_BITS-1:0] reg1;
	logic [`REG_IDX_BITS-1:0] reg2;
	logic [`REG_IDX_BITS-1:0] addr_reg;
	inst_decoder_pkg::src_e src;
	inst_decoder_pkg::addr_src_e addr_src;
	logic wide2;
	logic src_sext;
	logic autoinc;
	logic autoinc_neg;
	logic long_inst;
	logic special_reg2;
	logic swap_regs;
	logic cmp;
	logic test;
	logic use_rol;

	// zero-extend a 3-bit register field
	function automatic logic [`REG_IDX_BITS-1:0] reg_of(input logic [2:0] idx);
		return {{(`REG_IDX_BITS-3){1'b0}}, idx};
	endfunction

	assign imm6 = fields.imm6;
	assign d = fields.mdz[1];
	assign reg1 = reg_of(fields.r);

	// operand-2 table, first match wins
	always_comb begin
		src = inst_decoder_pkg::src_reg;
		addr_src = inst_decoder_pkg::asrc_none;
		addr_reg = '0;
		wide2 = fields.wide;
		src_sext = 1'b0;
		autoinc = 1'b0;
		autoinc_neg = 1'b0;
		reg2 = reg_of(imm6[2:0]);

		if (pre_stage) begin
			// push pc+n as [--sp] <- pc + imm2
			src = inst_decoder_pkg::src_imm2;
			addr_src = inst_decoder_pkg::asrc_imm2;
			addr_reg = `REG_INDEX_SP;
			autoinc = 1'b1;
			autoinc_neg = 1'b1;
		end else if (fields.use_imm8) begin
			src = inst_decoder_pkg::src_imm8;
			wide2 = 1'b0;
			src_sext = 1'b1;
		end else if (fields.use_zp) begin
			// zero page
			src = inst_decoder_pkg::src_mem;
			addr_src = inst_decoder_pkg::asrc_imm7;
		end else if (fields.mdz == 3'b101) begin
			src = inst_decoder_pkg::src_imm6;
			wide2 = 1'b0;
			src_sext = 1'b1;
		end else if (imm6[5]) begin
			// 1RRrrr [r16 + r8]
			src = inst_decoder_pkg::src_mem;
			addr_reg = reg_of({imm6[4:3], 1'b0});
			// offset inside the base pair means auto inc/dec
			autoinc = (imm6[4:3] == imm6[2:1]);
			autoinc_neg = autoinc && imm6[0];
			if (autoinc)
				addr_src = inst_decoder_pkg::asrc_imm2;
			else
				addr_src = inst_decoder_pkg::asrc_reg;
		end else if (imm6[4]) begin
			// 01RRii [r16 + imm2]
			src = inst_decoder_pkg::src_mem;
			addr_reg = reg_of({imm6[3:2], 1'b0});
			addr_src = inst_decoder_pkg::asrc_imm2;
		end else if (imm6[3] || !imm6[0]) begin
			// 001rrr r8, 000rr0 r16; d picks sext/zext
			wide2 = !imm6[3];
			src_sext = !d;
		end else begin
			// 000xy1
			case (imm6[2:1])
				2'b00: src = inst_decoder_pkg::src_imm16;
				2'b01: begin
					src = inst_decoder_pkg::src_mem;
					addr_src = inst_decoder_pkg::asrc_imm16;
				end
				2'b10: begin
					// push/pop, or plain [sp] for read-modify-write
					src = inst_decoder_pkg::src_mem;
					addr_src = inst_decoder_pkg::asrc_imm2;
					addr_reg = `REG_INDEX_SP;
					autoinc = (fields.cls == inst_decoder_pkg::cls_mov) || !fields.effective_d;
					autoinc_neg = fields.effective_d && autoinc;
				end
				default: reg2 = `REG_INDEX_SP;
			endcase
		end
		// shifts keep the operand width
		if (fields.cls == inst_decoder_pkg::cls_shift)
			wide2 = fields.wide;
	end

	// imm16 or [imm16] words are still unread when pc+n is pushed
	assign long_inst = !fields.branch && (imm6[5:2] == 4'b0000) && imm6[0];
	// sp tops the low half, so r8 index 7 aliases it
	assign special_reg2 = (src == inst_decoder_pkg::src_reg) && (reg2 == `REG_INDEX_SP);
	assign swap_regs = special_reg2 && fields.effective_d &&
		(fields.cls != inst_decoder_pkg::cls_shift);
	assign cmp = fields.cmptest && !d;
	assign test = fields.cmptest && d;
	// rol and shl run as subtract from zero
	assign use_rol = (fields.cls == inst_decoder_pkg::cls_shift) &&
		(fields.shift == inst_decoder_pkg::sh_rol || fields.shift == inst_decoder_pkg::sh_shl);

	always_comb begin
		uop.src1_pc = fields.branch || pre_stage;
		if (uop.src1_pc)
			uop.op = inst_decoder_pkg::op_add;
		else if (use_rol || cmp)
			uop.op = inst_decoder_pkg::op_sub;
		else if (test)
			uop.op = inst_decoder_pkg::op_and;
		else if (fields.cls == inst_decoder_pkg::cls_alu)
			uop.op = fields.binop;
		else
			uop.op = inst_decoder_pkg::op_mov;

		if ((fields.jump || fields.branch) && !pre_stage)
			uop.dest = inst_decoder_pkg::dest_pc;
		else if (fields.cls == inst_decoder_pkg::cls_shift)
			uop.dest = inst_decoder_pkg::dest_imm8;
		else if (pre_stage || (fields.effective_d && src == inst_decoder_pkg::src_mem))
			uop.dest = inst_decoder_pkg::dest_mem;
		else
			uop.dest = inst_decoder_pkg::dest_reg;

		uop.src = src;
		uop.reg_dest = swap_regs ? reg2 : reg1;
		uop.reg_src = swap_regs ? reg1 : reg2;
		uop.wide = fields.wide;
		uop.wide2 = wide2;
		uop.src_sext = src_sext;
		uop.addr_src = addr_src;
		uop.addr_reg = addr_reg;
		uop.autoinc = autoinc;
		uop.autoinc_neg = autoinc_neg;
		// cmp and test only set flags
		uop.update_dest = !fields.cmptest;
		uop.upd_flags = (fields.cls == inst_decoder_pkg::cls_alu);
		uop.upd_carry = (fields.cls == inst_decoder_pkg::cls_alu) &&
			(cmp || fields.binop < inst_decoder_pkg::op_and);
		uop.use_cc = fields.branch;
		uop.cc = fields.cc;
		uop.shift = fields.shift;
		if (pre_stage)
			uop.imm_words = long_inst ? 2'd2 : 2'd1;
		else
			uop.imm_words = 2'd0;

		// a memory write always carries an address from the operand table
		a_mem_dest: assert (uop.dest != inst_decoder_pkg::dest_mem ||
			addr_src != inst_decoder_pkg::asrc_none);
	end
endmodule

//--- design/uop_sequencer.sv
/*
  stage progression and the output micro-op register
  a call loads its push first, then its jump; ready low holds the register
*/
`timescale 1ns/10ps

module uop_sequencer (
	input logic clk,
	input logic rst,
	input logic inst_valid,
	input logic need_pre_stage,
	input inst_decoder_pkg::uop_t uop_next,
	output logic pre_stage,
	output logic inst_done,
	output logic uop_valid,
	input logic uop_ready,
	output inst_decoder_pkg::uop_t uop
);
	// set once the push of a call is loaded
	logic stage;
	logic load;

	assign pre_stage = need_pre_stage && !stage;
	// room when empty or drained on this edge
	assign load = inst_valid && (!uop_valid || uop_ready);
	// last micro-op of the instruction goes in
	assign inst_done = load && !pre_stage;

	always_ff @(posedge clk) begin
		if (rst) begin
			stage <= 1'b0;
			uop_valid <= 1'b0;
		end else begin
			if (load) begin
				// advance after the push, clear after the last step
				stage <= pre_stage;
				uop_valid <= 1'b1;
			end else if (uop_ready) begin
				uop_valid <= 1'b0;
			end
		end
	end

	// micro-op payload register
	always_ff @(posedge clk) begin
		if (load)
			uop <= uop_next;
	end

	// held micro-op stays put until taken
	a_hold: assert property (@(posedge clk) disable iff (rst)
		uop_valid && !uop_ready |=> uop_valid && $stable(uop));

	// jump step of a call only runs while that call is still presented
	a_stage: assert property (@(posedge clk) disable iff (rst)
		stage |-> inst_valid && need_pre_stage);
endmodule

//--- inst_decoder.f
+incdir+design
+incdir+sim
design/inst_decoder_pkg.sv
design/inst_fields_if.sv
design/inst_class_decode.sv
design/operand_decode.sv
design/uop_sequencer.sv
design/inst_decoder.sv
sim/tb_inst_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f inst_decoder.f \
	--top-module tb_inst_decoder \
	-o Vtb_inst_decoder

# the log decides pass or fail
./obj_dir/Vtb_inst_decoder > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
	exit 0
else
	exit 1
fi

//--- sim/decode_model.svh
/*
  reference decode for the testbench, rebuilt from the instruction format rules
  include inside the testbench module; model_uop gives one micro-op per stage
*/
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// top two bits give the kind, low bit splits ror from rol
function automatic inst_decoder_pkg::shift_e model_shift(input logic [1:0] top, input logic low);
	case (top)
		2'b10: return inst_decoder_pkg::sh_shr;
		2'b01: return inst_decoder_pkg::sh_sar;
		2'b11: return inst_decoder_pkg::sh_shl;
		default: return low ? inst_decoder_pkg::sh_rol : inst_decoder_pkg::sh_ror;
	endcase
endfunction

function automatic inst_decoder_pkg::uop_t model_uop(input logic [15:0] w, input logic pre,
		output logic need);
	inst_decoder_pkg::uop_t u;
	inst_decoder_pkg::cls_e cls;
	logic [2:0] aaa;
	logic [2:0] mdz;
	logic [2:0] r;
	logic [3:0] reg2;
	logic [5:0] i6;
	logic d;
	logic wide;
	logic zp;
	logic imm8;
	logic br;
	logic jmp;
	logic ct;
	logic effd;
	logic cmp;
	logic tst;
	logic swp;
	aaa = w[13:11];
	mdz = {w[10], w[7], w[6]};
	d = w[7];
	i6 = w[5:0];
	cls = inst_decoder_pkg::cls_mov;
	wide = 1'b0;
	r = 3'd0;
	zp = !w[10];
	imm8 = 1'b0;
	br = 1'b0;
	jmp = 1'b0;
	ct = 1'b0;
	effd = d;
	need = 1'b0;
	u.shift = model_shift(aaa[2:1], aaa[0]);
	if (w[15] || w[14]) begin
		// alu and shift forms
		wide = !w[15];
		r = {w[9:8], w[14] & w[15]};
		ct = (aaa == 3'd7);
		if (mdz == 3'b111)
			cls = inst_decoder_pkg::cls_shift;
		else
			cls = inst_decoder_pkg::cls_alu;
		if (mdz == 3'b111 || ct)
			effd = 1'b0;
	end else if (aaa[2] || aaa[1]) begin
		// move group
		wide = !aaa[2];
		r = {w[9:8], aaa[1] & aaa[2]};
		u.shift = model_shift(i6[5:4], 1'b0);
		if (!aaa[0]) begin
			if (w[10]) begin
				imm8 = 1'b1;
				effd = 1'b0;
			end
			if (w[10] == 1'b0 && d == 1'b0 && w[9:8] == 2'b00) begin
				jmp = !pre;
				if (!wide) begin
					// narrow jump is jump src, z makes it a call
					wide = 1'b1;
					zp = 1'b0;
					need = w[6];
				end
			end
			if (w[10] == 1'b0 && d == 1'b1)
				cls = inst_decoder_pkg::cls_swap;
		end else if (mdz == 3'b101) begin
			cls = inst_decoder_pkg::cls_shift;
		end else if (mdz == 3'b111) begin
			cls = inst_decoder_pkg::cls_swap;
		end
	end else begin
		// conditional branch on cccc
		wide = 1'b1;
		br = 1'b1;
		imm8 = 1'b1;
		effd = 1'b0;
		need = (w[11:8] == `CC_CALL);
	end

	// operand 2, first matching row
	u.src = inst_decoder_pkg::src_reg;
	u.addr_src = inst_decoder_pkg::asrc_none;
	u.addr_reg = 4'd0;
	u.wide2 = wide;
	u.src_sext = 1'b0;
	u.autoinc = 1'b0;
	u.autoinc_neg = 1'b0;
	reg2 = {1'b0, i6[2:0]};
	if (pre) begin
		u.src = inst_decoder_pkg::src_imm2;
		u.addr_src = inst_decoder_pkg::asrc_imm2;
		u.addr_reg = `REG_INDEX_SP;
		u.autoinc = 1'b1;
		u.autoinc_neg = 1'b1;
	end else if (imm8) begin
		u.src = inst_decoder_pkg::src_imm8;
		u.wide2 = 1'b0;
		u.src_sext = 1'b1;
	end else if (zp) begin
		u.src = inst_decoder_pkg::src_mem;
		u.addr_src = inst_decoder_pkg::asrc_imm7;
	end else if (mdz == 3'b101) begin
		u.src = inst_decoder_pkg::src_imm6;
		u.wide2 = 1'b0;
		u.src_sext = 1'b1;
	end else if (i6[5]) begin
		// [r16+r8], same pair means auto inc/dec
		u.src = inst_decoder_pkg::src_mem;
		u.addr_reg = {1'b0, i6[4:3], 1'b0};
		u.autoinc = (i6[4:3] == i6[2:1]);
		u.autoinc_neg = u.autoinc && i6[0];
		u.addr_src = u.autoinc ? inst_decoder_pkg::asrc_imm2 : inst_decoder_pkg::asrc_reg;
	end else if (i6[4]) begin
		u.src = inst_decoder_pkg::src_mem;
		u.addr_reg = {1'b0, i6[3:2], 1'b0};
		u.addr_src = inst_decoder_pkg::asrc_imm2;
	end else if (i6[3] || !i6[0]) begin
		u.wide2 = !i6[3];
		u.src_sext = !d;
	end else if (i6[2:1] == 2'b00) begin
		u.src = inst_decoder_pkg::src_imm16;
	end else if (i6[2:1] == 2'b01) begin
		u.src = inst_decoder_pkg::src_mem;
		u.addr_src = inst_decoder_pkg::asrc_imm16;
	end else if (i6[2:1] == 2'b10) begin
		// push, pop or plain [sp]
		u.src = inst_decoder_pkg::src_mem;
		u.addr_src = inst_decoder_pkg::asrc_imm2;
		u.addr_reg = `REG_INDEX_SP;
		u.autoinc = (cls == inst_decoder_pkg::cls_mov) || !effd;
		u.autoinc_neg = effd && u.autoinc;
	end else begin
		reg2 = `REG_INDEX_SP;
	end
	if (cls == inst_decoder_pkg::cls_shift)
		u.wide2 = wide;

	// derived control
	cmp = ct && !d;
	tst = ct && d;
	u.src1_pc = br || pre;
	if (u.src1_pc)
		u.op = inst_decoder_pkg::op_add;
	else if (cmp || (cls == inst_decoder_pkg::cls_shift &&
			(u.shift == inst_decoder_pkg::sh_rol || u.shift == inst_decoder_pkg::sh_shl)))
		u.op = inst_decoder_pkg::op_sub;
	else if (tst)
		u.op = inst_decoder_pkg::op_and;
	else if (cls == inst_decoder_pkg::cls_alu)
		u.op = inst_decoder_pkg::op_e'(aaa);
	else
		u.op = inst_decoder_pkg::op_mov;
	if ((jmp || br) && !pre)
		u.dest = inst_decoder_pkg::dest_pc;
	else if (cls == inst_decoder_pkg::cls_shift)
		u.dest = inst_decoder_pkg::dest_imm8;
	else if (pre || (effd && u.src == inst_decoder_pkg::src_mem))
		u.dest = inst_decoder_pkg::dest_mem;
	else
		u.dest = inst_decoder_pkg::dest_reg;
	// special operand-2 register written through d swaps roles
	swp = (u.src == inst_decoder_pkg::src_reg) && (reg2 == `REG_INDEX_SP) && effd &&
		(cls != inst_decoder_pkg::cls_shift);
	u.reg_dest = swp ? reg2 : {1'b0, r};
	u.reg_src = swp ? {1'b0, r} : reg2;
	u.wide = wide;
	u.update_dest = !ct;
	u.upd_flags = (cls == inst_decoder_pkg::cls_alu);
	u.upd_carry = (cls == inst_decoder_pkg::cls_alu) && (cmp || aaa < 3'd4);
	u.use_cc = br;
	u.cc = w[11:8];
	if (!pre)
		u.imm_words = 2'd0;
	else if (!br && i6[5:2] == 4'b0000 && i6[0])
		u.imm_words = 2'd2;
	else
		u.imm_words = 2'd1;
	return u;
endfunction

// queue the micro-ops one instruction should produce
task automatic expect_inst(input logic [15:0] w);
	inst_decoder_pkg::uop_t u;
	logic need;
	u = model_uop(w, 1'b0, need);
	if (need)
		expected_q.push_back(model_uop(w, 1'b1, need));
	expected_q.push_back(model_uop(w, 1'b0, need));
endtask

`endif

//--- sim/tb_inst_decoder.sv
/*
  testbench for the instruction decoder with random words and random ready,
  each accepted micro-op checked against the reference model in order
*/
`timescale 1ns/10ps
`include "inst_decoder_params.svh"

module tb_inst_decoder;
	localparam int NUM_INST = 2000;
	localparam int TIMEOUT_NS = NUM_INST * 2 * 20 * 100;

	logic clk;
	logic rst;
	logic inst_valid;
	logic [`INST_BITS-1:0] inst;
	logic inst_done;
	logic uop_valid;
	logic uop_ready;
	inst_decoder_pkg::op_e uop_op;
	inst_decoder_pkg::dest_e uop_dest;
	inst_decoder_pkg::src_e uop_src;
	logic [`REG_IDX_BITS-1:0] uop_reg_dest;
	logic [`REG_IDX_BITS-1:0] uop_reg_src;
	logic uop_wide;
	logic uop_wide2;
	logic uop_src_sext;
	inst_decoder_pkg::addr_src_e uop_addr_src;
	logic [`REG_IDX_BITS-1:0] uop_addr_reg;
	logic uop_autoinc;
	logic uop_autoinc_neg;
	logic uop_src1_pc;
	logic uop_update_dest;
	logic uop_upd_carry;
	logic uop_upd_flags;
	logic uop_use_cc;
	logic [3:0] uop_cc;
	inst_decoder_pkg::shift_e uop_shift;
	logic [1:0] uop_imm_words;

	logic [31:0] lfsr;
	inst_decoder_pkg::uop_t expected_q[$];

	`include "decode_model.svh"

	inst_decoder uut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = !clk;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error %s: expected %0h, actual %0h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	function automatic inst_decoder_pkg::uop_t port_uop();
		inst_decoder_pkg::uop_t u;
		u.op = uop_op;
		u.dest = uop_dest;
		u.src = uop_src;
		u.reg_dest = uop_reg_dest;
		u.reg_src = uop_reg_src;
		u.wide = uop_wide;
		u.wide2 = uop_wide2;
		u.src_sext = uop_src_sext;
		u.addr_src = uop_addr_src;
		u.addr_reg = uop_addr_reg;
		u.autoinc = uop_autoinc;
		u.autoinc_neg = uop_autoinc_neg;
		u.src1_pc = uop_src1_pc;
		u.update_dest = uop_update_dest;
		u.upd_carry = uop_upd_carry;
		u.upd_flags = uop_upd_flags;
		u.use_cc = uop_use_cc;
		u.cc = uop_cc;
		u.shift = uop_shift;
		u.imm_words = uop_imm_words;
		return u;
	endfunction

	task automatic check_uop(input inst_decoder_pkg::uop_t e, input inst_decoder_pkg::uop_t a,
			input string label);
		compare({label, " op"}, 32'(e.op), 32'(a.op));
		compare({label, " dest"}, 32'(e.dest), 32'(a.dest));
		compare({label, " src"}, 32'(e.src), 32'(a.src));
		compare({label, " reg_dest"}, 32'(e.reg_dest), 32'(a.reg_dest));
		compare({label, " reg_src"}, 32'(e.reg_src), 32'(a.reg_src));
		compare({label, " wide"}, 32'(e.wide), 32'(a.wide));
		compare({label, " wide2"}, 32'(e.wide2), 32'(a.wide2));
		compare({label, " src_sext"}, 32'(e.src_sext), 32'(a.src_sext));
		compare({label, " addr_src"}, 32'(e.addr_src), 32'(a.addr_src));
		compare({label, " addr_reg"}, 32'(e.addr_reg), 32'(a.addr_reg));
		compare({label, " autoinc"}, 32'(e.autoinc), 32'(a.autoinc));
		compare({label, " autoinc_neg"}, 32'(e.autoinc_neg), 32'(a.autoinc_neg));
		compare({label, " src1_pc"}, 32'(e.src1_pc), 32'(a.src1_pc));
		compare({label, " update_dest"}, 32'(e.update_dest), 32'(a.update_dest));
		compare({label, " upd_carry"}, 32'(e.upd_carry), 32'(a.upd_carry));
		compare({label, " upd_flags"}, 32'(e.upd_flags), 32'(a.upd_flags));
		compare({label, " use_cc"}, 32'(e.use_cc), 32'(a.use_cc));
		compare({label, " cc"}, 32'(e.cc), 32'(a.cc));
		compare({label, " shift"}, 32'(e.shift), 32'(a.shift));
		compare({label, " imm_words"}, 32'(e.imm_words), 32'(a.imm_words));
	endtask

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: decoder stopped producing micro-ops");
		$display("TESTS FAILED");
		$fatal(1);
	end

	initial begin
		inst_decoder_pkg::uop_t act;
		inst_decoder_pkg::uop_t held;
		logic held_valid;
		logic busy;
		int issued;
		int accepted;
		int done_count;
		logic [15:0] w;
		lfsr = 32'h9271_9c8f;
		rst = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		uop_ready = 1'b0;
		held_valid = 1'b0;
		busy = 1'b0;
		issued = 0;
		accepted = 0;
		done_count = 0;

		// outputs quiet through reset and just after
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			if (i > 0) begin
				compare("reset uop_valid", 32'd0, 32'(uop_valid));
				compare("reset inst_done", 32'd0, 32'(inst_done));
			end
		end
		rst <= 1'b0;
		@(posedge clk);
		compare("after reset uop_valid", 32'd0, 32'(uop_valid));
		compare("after reset inst_done", 32'd0, 32'(inst_done));

		forever begin
			act = port_uop();
			if (held_valid) begin
				compare("hold uop_valid", 32'd1, 32'(uop_valid));
				check_uop(held, act, $sformatf("hold uop %0d", accepted));
			end
			if (uop_valid && uop_ready) begin
				if (expected_q.size() == 0) begin
					$display("micro-op accepted with none expected");
					$display("TESTS FAILED");
					$fatal(1);
				end else begin
					check_uop(expected_q.pop_front(), act, $sformatf("uop %0d", accepted));
					accepted++;
				end
			end
			held_valid = uop_valid && !uop_ready;
			held = act;
			if (inst_done) begin
				done_count++;
				busy = 1'b0;
			end
			// next word once the current one is done
			if (!busy) begin
				if (issued < NUM_INST) begin
					w = 16'(rand_bits(16));
					// every 64th word a narrow call whose operand is imm16 or [imm16]
					if (issued % 64 == 63)
						w = {3'b001, w[0], 4'b0000, 2'b01, 4'b0000, w[1], 1'b1};
					inst <= w;
					inst_valid <= 1'b1;
					expect_inst(w);
					issued++;
					busy = 1'b1;
				end else begin
					inst_valid <= 1'b0;
				end
			end
			// ready about 70 % of the time
			uop_ready <= (rand_bits(4) < 32'd11);
			if (issued == NUM_INST && !busy && expected_q.size() == 0)
				break;
			@(posedge clk);
		end
		compare("inst_done count", 32'(NUM_INST), 32'(done_count));
		$display("TESTS PASSED");
		$finish;
	end
endmodule
